/* project.f */
+incdir+common
common/cps_video_pkg.sv
mmr/cpsa_regs.sv
mmr/cpsb_regs.sv
hdl/cpsb_game_map.sv
hdl/bus_decode.sv
hdl/cps_video_regs.sv
verif/tb_cps_video_regs.sv

/* Bender.yml */
package:
  name: cps_video_regs

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cps_video_pkg.sv
      - mmr/cpsa_regs.sv
      - mmr/cpsb_regs.sv
      - hdl/cpsb_game_map.sv
      - hdl/bus_decode.sv
      - hdl/cps_video_regs.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/tb_cps_video_regs.sv

/* verif/tb_cps_video_regs.sv */
// Testbench for the video register block. A stimulus table per game is applied
// one entry at a time and the DUT ports are compared with a reference model.
`timescale 1ns/1ps
`default_nettype none
`include "cps_video_config.svh"

module tb_cps_video_regs;

    localparam logic [23:0] cpsa_win = 24'h800100;
    localparam logic [23:0] cpsb_win = 24'h800140;

    logic                      clk;
    logic                      reg_rst;
    logic                      ppu_rstn;
    logic [`GAME_ID_W-1:0]     game_id;
    cps_video_pkg::cpu_bus_t   bus;
    cps_video_pkg::cpsa_regs_t cpsa;
    cps_video_pkg::cpsb_regs_t cpsb;
    logic [15:0]               rdata;

    // Stimulus table, one column per queue
    string       q_name[$];
    int          q_game[$];
    bit          q_rnw[$];
    logic [23:0] q_addr[$];
    logic [1:0]  q_dsn[$];
    logic [15:0] q_data[$];
    logic [15:0] q_exp[$];

    // Reference model state
    cps_video_pkg::cpsa_regs_t exp_a;
    cps_video_pkg::cpsb_regs_t exp_b;
    logic [15:0]               exp_rd;

    int cpsa_err;
    int cpsb_err;
    int rdata_err;
    bit table_ready;
    int cur_game;

    cps_video_regs i_cps_video_regs (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu_rstn (ppu_rstn),
        .game_id  (game_id),
        .bus      (bus),
        .cpsa     (cpsa),
        .cpsb     (cpsb),
        .rdata    (rdata)
    );

    always #50 clk = ~clk;

    // Game table: r = 0 layer, 1 to 4 prio0 to prio3, 5 pal_page, 6 id
    function automatic logic [4:0] game_offset(input int g, input int r);
        logic [34:0] row;
        case (g)
            0: row = {5'h13, 5'h14, 5'h15, 5'h16, 5'h17, 5'h18, 5'h12};
            1: row = {5'h16, 5'h15, 5'h14, 5'h13, 5'h12, 5'h18, 5'h10};
            2: row = {5'h06, 5'h07, 5'h08, 5'h09, 5'h0a, 5'h0b, 5'h00};
            default: row = {5'h14, 5'h13, 5'h12, 5'h11, 5'h10, 5'h18, 5'h19};
        endcase
        return row[(6 - r) * 5 +: 5];
    endfunction

    function automatic logic [15:0] game_id_word(input int g);
        return (g == 0) ? 16'h0000 : 16'h0400 + 16'(g);
    endfunction

    // Bytes whose strobe is low take the new data
    function automatic logic [15:0] keep_lanes(input logic [15:0] old_data,
                                               input logic [15:0] new_data,
                                               input logic [1:0]  ds_n);
        logic [15:0] mask;
        mask = {{8{~ds_n[1]}}, {8{~ds_n[0]}}};
        return (old_data & ~mask) | (new_data & mask);
    endfunction

    task automatic add_entry(input string name, input int g, input bit rnw,
                             input logic [23:0] baddr, input logic [1:0] dsn,
                             input logic [15:0] data, input logic [15:0] exp);
        q_name.push_back(name);
        q_game.push_back(g);
        q_rnw.push_back(rnw);
        q_addr.push_back(baddr);
        q_dsn.push_back(dsn);
        q_data.push_back(data);
        q_exp.push_back(exp);
    endtask

    task automatic build_table();
        int          g;
        int          off;
        int          r;
        logic [4:0]  free_off;
        logic [4:0]  id_off;
        for (g = 0; g < 4; g++) begin
            id_off = game_offset(g, 6);
            for (off = 0; off < 18; off++)
                add_entry($sformatf("g%0d_cpsa_off%02h", g, off), g, 0, cpsa_win + off * 2,
                          2'b00, 16'h1000 * (g + 1) + off * 16'h0101, 16'h0000);
            add_entry($sformatf("g%0d_cpsa_unused12", g), g, 0, cpsa_win + 24'h24, 2'b00,
                      16'hDEAD, 16'h0000);
            add_entry($sformatf("g%0d_cpsa_unused1f", g), g, 0, cpsa_win + 24'h3e, 2'b00,
                      16'hDEAD, 16'h0000);
            add_entry($sformatf("g%0d_cpsa_upper", g), g, 0, cpsa_win + 24'h0c, 2'b01,
                      16'hA5C3, 16'h0000);
            add_entry($sformatf("g%0d_cpsa_lower", g), g, 0, cpsa_win + 24'h0c, 2'b10,
                      16'h5A3C, 16'h0000);
            add_entry($sformatf("g%0d_cpsa_none", g), g, 0, cpsa_win + 24'h0c, 2'b11,
                      16'hFFFF, 16'h0000);
            for (r = 0; r < 6; r++)
                add_entry($sformatf("g%0d_cpsb_reg%0d", g, r), g, 0,
                          cpsb_win + game_offset(g, r) * 2, 2'b00,
                          16'h2000 * (g + 1) + r * 16'h0111, 16'h0000);
            add_entry($sformatf("g%0d_layer_upper", g), g, 0, cpsb_win + game_offset(g, 0) * 2,
                      2'b01, 16'hC35A, 16'h0000);
            add_entry($sformatf("g%0d_layer_lower", g), g, 0, cpsb_win + game_offset(g, 0) * 2,
                      2'b10, 16'h3CA5, 16'h0000);
            add_entry($sformatf("g%0d_layer_none", g), g, 0, cpsb_win + game_offset(g, 0) * 2,
                      2'b11, 16'h0000, 16'h0000);
            add_entry($sformatf("g%0d_pal_upper", g), g, 0, cpsb_win + game_offset(g, 5) * 2,
                      2'b01, 16'hFF00, 16'h0000);
            add_entry($sformatf("g%0d_pal_lower", g), g, 0, cpsb_win + game_offset(g, 5) * 2,
                      2'b10, 16'h00D5, 16'h0000);
            // Layer offset of another game, unused in this map
            free_off = (g == 2) ? game_offset(0, 0) : game_offset(2, 0);
            add_entry($sformatf("g%0d_cpsb_free", g), g, 0, cpsb_win + free_off * 2, 2'b00,
                      16'h7777, 16'h0000);
            add_entry($sformatf("g%0d_outside_hi", g), g, 0, 24'h800180, 2'b00, 16'hBEEF,
                      16'h0000);
            add_entry($sformatf("g%0d_outside_lo", g), g, 0, 24'h8000FE, 2'b00, 16'hBEEF,
                      16'h0000);
            for (r = 0; r < 4; r++) begin
                add_entry($sformatf("g%0d_rnd_cpsa%0d", g, r), g, 0,
                          cpsa_win + ($urandom % 32) * 2, 2'($urandom), 16'($urandom), 16'h0);
                add_entry($sformatf("g%0d_rnd_cpsb%0d", g, r), g, 0,
                          cpsb_win + ($urandom % 32) * 2, 2'($urandom), 16'($urandom), 16'h0);
            end
            // Reads near the end, so the ID word is held when the next reset comes
            add_entry($sformatf("g%0d_rd_id", g), g, 1, cpsb_win + id_off * 2, 2'b00,
                      16'h0000, game_id_word(g));
            add_entry($sformatf("g%0d_rd_cpsa", g), g, 1, cpsa_win + id_off * 2, 2'b00,
                      16'h0000, 16'h0000);
            add_entry($sformatf("g%0d_rd_layer", g), g, 1, cpsb_win + game_offset(g, 0) * 2,
                      2'b00, 16'h0000, 16'h0000);
            add_entry($sformatf("g%0d_rd_outside", g), g, 1, 24'h800200, 2'b00, 16'h0000,
                      16'h0000);
            add_entry($sformatf("g%0d_rd_id_last", g), g, 1, cpsb_win + id_off * 2, 2'b00,
                      16'h0000, game_id_word(g));
            // A write after the last read leaves the ID word in rdata
            add_entry($sformatf("g%0d_wr_after_rd", g), g, 0, cpsa_win + 24'h02, 2'b00,
                      16'h4321, 16'h0000);
        end
    endtask

    task automatic model_reset();
        exp_a             = '0;
        exp_b.layer_ctrl  = 16'h0000;
        exp_b.prio0       = 16'hFFFF;
        exp_b.prio1       = 16'hFFFF;
        exp_b.prio2       = 16'hFFFF;
        exp_b.prio3       = 16'hFFFF;
        exp_b.pal_page_en = 6'h3F;
        exp_rd            = 16'h0000;
    endtask

    task automatic model_write(input int g, input logic [23:0] baddr, input logic [1:0] dsn,
                               input logic [15:0] data);
        int idx;
        idx = int'(baddr[5:1]);
        if (baddr[23:6] == cpsa_win[23:6]) begin
            if (idx < 18)
                exp_a[(17 - idx) * 16 +: 16] = keep_lanes(exp_a[(17 - idx) * 16 +: 16],
                                                          data, dsn);
        end else if (baddr[23:6] == cpsb_win[23:6]) begin
            if (baddr[5:1] == game_offset(g, 0))
                exp_b.layer_ctrl = keep_lanes(exp_b.layer_ctrl, data, dsn);
            if (baddr[5:1] == game_offset(g, 1))
                exp_b.prio0 = keep_lanes(exp_b.prio0, data, dsn);
            if (baddr[5:1] == game_offset(g, 2))
                exp_b.prio1 = keep_lanes(exp_b.prio1, data, dsn);
            if (baddr[5:1] == game_offset(g, 3))
                exp_b.prio2 = keep_lanes(exp_b.prio2, data, dsn);
            if (baddr[5:1] == game_offset(g, 4))
                exp_b.prio3 = keep_lanes(exp_b.prio3, data, dsn);
            if (baddr[5:1] == game_offset(g, 5) && !dsn[0])
                exp_b.pal_page_en = data[5:0];
        end
    endtask

    task automatic check_outputs(input string name);
        assert (cpsa === exp_a) else begin
            cpsa_err++;
            $display("mismatch %s cpsa expected %h actual %h", name, exp_a, cpsa);
        end
        assert (cpsb === exp_b) else begin
            cpsb_err++;
            $display("mismatch %s cpsb expected %h actual %h", name, exp_b, cpsb);
        end
        assert (rdata === exp_rd) else begin
            rdata_err++;
            $display("mismatch %s rdata expected %h actual %h", name, exp_rd, rdata);
        end
    endtask

    task automatic board_reset(input int g);
        @(posedge clk);
        game_id <= 2'(g);
        reg_rst <= 1'b1;
        repeat (4) @(posedge clk);
        reg_rst <= 1'b0;
        // Map picks up the new game at this edge
        @(posedge clk);
        model_reset();
        @(negedge clk);
        check_outputs($sformatf("g%0d_reg_reset", g));
    endtask

    task automatic ppu_reset(input int g);
        @(posedge clk);
        ppu_rstn <= 1'b0;
        repeat (2) @(posedge clk);
        ppu_rstn <= 1'b1;
        model_reset();
        @(negedge clk);
        check_outputs($sformatf("g%0d_ppu_reset", g));
    endtask

    task automatic apply_entry(input int i);
        cps_video_pkg::cpu_bus_t cyc;
        cyc.as    = 1'b1;
        cyc.rnw   = q_rnw[i];
        cyc.addr  = q_addr[i][23:1];
        cyc.dsn   = q_dsn[i];
        cyc.wdata = q_data[i];
        @(posedge clk);
        bus <= cyc;
        @(posedge clk);
        bus <= '0;
        if (q_rnw[i])
            exp_rd = q_exp[i];
        else
            model_write(q_game[i], q_addr[i], q_dsn[i], q_data[i]);
        @(negedge clk);
        check_outputs(q_name[i]);
    endtask

    initial begin : watchdog
        longint limit_cycles;
        wait (table_ready);
        limit_cycles = q_name.size() * 2 + 4 * 8 + 200;
        #(limit_cycles * 100);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("errors: cpsa %0d cpsb %0d rdata %0d", cpsa_err, cpsb_err, rdata_err);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        reg_rst  = 1'b1;
        ppu_rstn = 1'b1;
        game_id  = '0;
        bus      = '0;
        void'($urandom(25));
        build_table();
        table_ready = 1'b1;
        cur_game = -1;
        for (int i = 0; i < q_name.size(); i++) begin
            if (q_game[i] != cur_game) begin
                if (cur_game >= 0)
                    ppu_reset(cur_game);
                cur_game = q_game[i];
                board_reset(cur_game);
            end
            apply_entry(i);
        end
        ppu_reset(cur_game);
        $display("errors: cpsa %0d cpsb %0d rdata %0d", cpsa_err, cpsb_err, rdata_err);
        if (cpsa_err + cpsb_err + rdata_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cps_video_regs.sv */
// Top level of the video register block. Connects the bus decoder, the
// per-game CPS-B map and the two register banks.
`timescale 1ns/1ps
`default_nettype none
`include "cps_video_config.svh"

module cps_video_regs (
    input  logic                      clk,
    input  logic                      reg_rst,
    input  logic                      ppu_rstn,
    input  logic [`GAME_ID_W-1:0]     game_id,
    input  cps_video_pkg::cpu_bus_t   bus,
    output cps_video_pkg::cpsa_regs_t cpsa,
    output cps_video_pkg::cpsb_regs_t cpsb,
    output logic [15:0]               rdata
);

    logic                     cpsa_wr;
    logic                     cpsb_wr;
    logic                     regs_rst;
    cps_video_pkg::cpsb_map_t map;

    bus_decode i_bus_decode (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .ppu_rstn (ppu_rstn),
        .bus      (bus),
        .map      (map),
        .cpsa_wr  (cpsa_wr),
        .cpsb_wr  (cpsb_wr),
        .regs_rst (regs_rst),
        .rdata    (rdata)
    );

    cpsb_game_map i_cpsb_game_map (
        .clk     (clk),
        .reg_rst (reg_rst),
        .game_id (game_id),
        .map     (map)
    );

    cpsa_regs i_cpsa_regs (
        .clk      (clk),
        .regs_rst (regs_rst),
        .wr       (cpsa_wr),
        .bus      (bus),
        .regs     (cpsa)
    );

    cpsb_regs i_cpsb_regs (
        .clk      (clk),
        .regs_rst (regs_rst),
        .wr       (cpsb_wr),
        .bus      (bus),
        .map      (map),
        .regs     (cpsb)
    );

endmodule

`default_nettype wire

/* hdl/bus_decode.sv */
// CPU bus decoder: window chip selects, combined register reset and the
// registered read data path for the CPS-B identification word.
`timescale 1ns/1ps
`default_nettype none
`include "cps_video_config.svh"

module bus_decode (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  logic                     ppu_rstn,
    input  cps_video_pkg::cpu_bus_t  bus,
    input  cps_video_pkg::cpsb_map_t map,
    output logic                     cpsa_wr,
    output logic                     cpsb_wr,
    output logic                     regs_rst,
    output logic [15:0]              rdata
);

    localparam logic [23:1] cpsa_base = `CPSA_BASE;
    localparam logic [23:1] cpsb_base = `CPSB_BASE;
    localparam int          win_lsb   = `WIN_ADDR_W + 1;

    logic cpsa_sel;
    logic cpsb_sel;
    logic id_rd;

    // Only the bits above the register offset select the window
    assign cpsa_sel = bus.as && (bus.addr[23:win_lsb] == cpsa_base[23:win_lsb]);
    assign cpsb_sel = bus.as && (bus.addr[23:win_lsb] == cpsb_base[23:win_lsb]);

    assign cpsa_wr = cpsa_sel && !bus.rnw;
    assign cpsb_wr = cpsb_sel && !bus.rnw;

    assign regs_rst = reg_rst || !ppu_rstn;

    assign id_rd = cpsb_sel && bus.rnw && (bus.addr[5:1] == map.off_id);

    // Read data changes only on read cycles and holds in between
    always_ff @(posedge clk or posedge regs_rst) begin
        if (regs_rst) begin
            rdata <= 16'h0000;
        end else if (bus.as && bus.rnw) begin
            rdata <= id_rd ? map.id_word : 16'h0000;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpsb_game_map.sv */
// Per-game table of CPS-B register offsets and the ID word read back by
// the CPU. The entry for game_id is registered at every clock edge.
`timescale 1ns/1ps
`default_nettype none
`include "cps_video_config.svh"

module cpsb_game_map (
    input  logic                     clk,
    input  logic                     reg_rst,
    input  logic [`GAME_ID_W-1:0]    game_id,
    output cps_video_pkg::cpsb_map_t map
);

    // Order: layer, prio0 to prio3, pal_page, id, ID word
    localparam cps_video_pkg::cpsb_map_t game_tbl [`GAME_CNT] = '{
        '{5'h13, 5'h14, 5'h15, 5'h16, 5'h17, 5'h18, 5'h12, 16'h0000},
        '{5'h16, 5'h15, 5'h14, 5'h13, 5'h12, 5'h18, 5'h10, 16'h0401},
        '{5'h06, 5'h07, 5'h08, 5'h09, 5'h0a, 5'h0b, 5'h00, 16'h0402},
        '{5'h14, 5'h13, 5'h12, 5'h11, 5'h10, 5'h18, 5'h19, 16'h0403}
    };

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            map <= game_tbl[0];
        end else begin
            map <= game_tbl[game_id];
        end
    end

endmodule

`default_nettype wire

/* mmr/cpsb_regs.sv */
// CPS-B register bank. Register offsets come from the per-game map, so
// every register whose offset matches the write address takes the data.
`timescale 1ns/1ps
`default_nettype none
`include "cps_video_config.svh"

module cpsb_regs (
    input  logic                     clk,
    input  logic                     regs_rst,
    input  logic                     wr,
    input  cps_video_pkg::cpu_bus_t  bus,
    input  cps_video_pkg::cpsb_map_t map,
    output cps_video_pkg::cpsb_regs_t regs
);

    logic [4:0]  offset;
    logic [15:0] pal_merged;

    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_data,
        input logic [15:0] new_data,
        input logic [1:0]  ds_n
    );
        return {ds_n[1] ? old_data[15:8] : new_data[15:8],
                ds_n[0] ? old_data[7:0]  : new_data[7:0]};
    endfunction

    assign offset = bus.addr[5:1];

    // Palette page enables live in the low byte only
    assign pal_merged = lane_merge({10'h000, regs.pal_page_en}, bus.wdata, bus.dsn);

    always_ff @(posedge clk or posedge regs_rst) begin
        if (regs_rst) begin
            regs.layer_ctrl  <= 16'h0000;
            regs.prio0       <= `PRIO_RST;
            regs.prio1       <= `PRIO_RST;
            regs.prio2       <= `PRIO_RST;
            regs.prio3       <= `PRIO_RST;
            regs.pal_page_en <= `PAL_PAGE_RST;
        end else if (wr) begin
            if (offset == map.off_layer)
                regs.layer_ctrl <= lane_merge(regs.layer_ctrl, bus.wdata, bus.dsn);
            if (offset == map.off_prio0)
                regs.prio0 <= lane_merge(regs.prio0, bus.wdata, bus.dsn);
            if (offset == map.off_prio1)
                regs.prio1 <= lane_merge(regs.prio1, bus.wdata, bus.dsn);
            if (offset == map.off_prio2)
                regs.prio2 <= lane_merge(regs.prio2, bus.wdata, bus.dsn);
            if (offset == map.off_prio3)
                regs.prio3 <= lane_merge(regs.prio3, bus.wdata, bus.dsn);
            if (offset == map.off_pal_page)
                regs.pal_page_en <= pal_merged[5:0];
        end
    end

endmodule

`default_nettype wire

/* mmr/cpsa_regs.sv */
// CPS-A register bank: eighteen 16-bit registers at fixed word offsets.
// A write strobe from the bus decoder merges the CPU data by byte lane.
`timescale 1ns/1ps
`default_nettype none

module cpsa_regs (
    input  logic                    clk,
    input  logic                    regs_rst,
    input  logic                    wr,
    input  cps_video_pkg::cpu_bus_t bus,
    output cps_video_pkg::cpsa_regs_t regs
);

    // Keep the byte whose strobe is high, take the new byte otherwise
    function automatic logic [15:0] byte_merge(
        input logic [15:0] old_data,
        input logic [15:0] new_data,
        input logic [1:0]  ds_n
    );
        logic [15:0] merged;
        merged[15:8] = ds_n[1] ? old_data[15:8] : new_data[15:8];
        merged[7:0]  = ds_n[0] ? old_data[7:0]  : new_data[7:0];
        return merged;
    endfunction

    always_ff @(posedge clk or posedge regs_rst) begin
        if (regs_rst) begin
            regs <= '0;
        end else if (wr) begin
            case (bus.addr[5:1])
                // VRAM bases and palette
                5'h00: regs.vram_obj_base <= byte_merge(regs.vram_obj_base, bus.wdata, bus.dsn);
                5'h01: regs.vram1_base    <= byte_merge(regs.vram1_base, bus.wdata, bus.dsn);
                5'h02: regs.vram2_base    <= byte_merge(regs.vram2_base, bus.wdata, bus.dsn);
                5'h03: regs.vram3_base    <= byte_merge(regs.vram3_base, bus.wdata, bus.dsn);
                5'h04: regs.vram_row_base <= byte_merge(regs.vram_row_base, bus.wdata, bus.dsn);
                5'h05: regs.pal_base      <= byte_merge(regs.pal_base, bus.wdata, bus.dsn);
                // Scroll layers 1 to 3
                5'h06: regs.hpos1         <= byte_merge(regs.hpos1, bus.wdata, bus.dsn);
                5'h07: regs.vpos1         <= byte_merge(regs.vpos1, bus.wdata, bus.dsn);
                5'h08: regs.hpos2         <= byte_merge(regs.hpos2, bus.wdata, bus.dsn);
                5'h09: regs.vpos2         <= byte_merge(regs.vpos2, bus.wdata, bus.dsn);
                5'h0a: regs.hpos3         <= byte_merge(regs.hpos3, bus.wdata, bus.dsn);
                5'h0b: regs.vpos3         <= byte_merge(regs.vpos3, bus.wdata, bus.dsn);
                // Starfields
                5'h0c: regs.hstar1        <= byte_merge(regs.hstar1, bus.wdata, bus.dsn);
                5'h0d: regs.vstar1        <= byte_merge(regs.vstar1, bus.wdata, bus.dsn);
                5'h0e: regs.hstar2        <= byte_merge(regs.hstar2, bus.wdata, bus.dsn);
                5'h0f: regs.vstar2        <= byte_merge(regs.vstar2, bus.wdata, bus.dsn);
                5'h10: regs.vram_star_base <= byte_merge(regs.vram_star_base, bus.wdata,
                                                         bus.dsn);
                5'h11: regs.ppu_ctrl      <= byte_merge(regs.ppu_ctrl, bus.wdata, bus.dsn);
                // Offsets 0x12 and up hold nothing in this bank
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* common/cps_video_pkg.sv */
// Shared types of the video register block: CPU bus cycle, both register banks
// and the per-game CPS-B offset map. Referenced by scoped names only.
`default_nettype none

package cps_video_pkg;

    // One CPU bus cycle, sampled at every rising clock edge
    typedef struct packed {
        logic        as;     // Access strobe
        logic        rnw;    // High for read, low for write
        logic [23:1] addr;   // Word address
        logic [1:0]  dsn;    // Byte strobes, active low, bit 1 is upper byte
        logic [15:0] wdata;
    } cpu_bus_t;

    // CPS-A bank, fields in word offset order starting at 0x00
    typedef struct packed {
        logic [15:0] vram_obj_base;
        logic [15:0] vram1_base;
        logic [15:0] vram2_base;
        logic [15:0] vram3_base;
        logic [15:0] vram_row_base;
        logic [15:0] pal_base;
        logic [15:0] hpos1;
        logic [15:0] vpos1;
        logic [15:0] hpos2;
        logic [15:0] vpos2;
        logic [15:0] hpos3;
        logic [15:0] vpos3;
        logic [15:0] hstar1;
        logic [15:0] vstar1;
        logic [15:0] hstar2;
        logic [15:0] vstar2;
        logic [15:0] vram_star_base;
        logic [15:0] ppu_ctrl;
    } cpsa_regs_t;

    // CPS-B bank
    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [5:0]  pal_page_en;  // One enable bit per palette page
    } cpsb_regs_t;

    // Word offsets of the CPS-B registers inside their window, per game
    typedef struct packed {
        logic [4:0]  off_layer;
        logic [4:0]  off_prio0;
        logic [4:0]  off_prio1;
        logic [4:0]  off_prio2;
        logic [4:0]  off_prio3;
        logic [4:0]  off_pal_page;
        logic [4:0]  off_id;
        logic [15:0] id_word;
    } cpsb_map_t;

endpackage

`default_nettype wire

/* common/cps_video_config.svh */
// Address windows, game count and reset values of the video register block.
// Included by the modules that decode addresses or reset the CPS-B bank.
`ifndef CPS_VIDEO_CONFIG_SVH
`define CPS_VIDEO_CONFIG_SVH

// CPS-A window, byte addresses 0x800100 to 0x80013F
`define CPSA_BASE 23'h400080

// CPS-B window, byte addresses 0x800140 to 0x80017F
`define CPSB_BASE 23'h4000A0

// Number of address bits that select a register inside a window
`define WIN_ADDR_W 5

// Game selection
`define GAME_ID_W 2
`define GAME_CNT  4

// CPS-B reset values, all layers masked and all palette pages enabled
`define PRIO_RST     16'hFFFF
`define PAL_PAGE_RST 6'h3F

`endif
